/* fpga2cpu_dma.f */
src/cpu_dma_pkg.sv
src/dma_wr_if.sv
src/showahead_fifo.sv
src/bus_write_master.sv
src/transfer_ctrl.sv
src/fpga2cpu_dma.sv
verification/tb_fpga2cpu_dma.sv

/* Makefile */
TOP = tb_fpga2cpu_dma
OBJ = obj_dir

.PHONY: all lint clean

all: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

$(OBJ)/V$(TOP): fpga2cpu_dma.f src/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f fpga2cpu_dma.f -o V$(TOP)

lint:
	verilator --lint-only --timing --top-module fpga2cpu_dma \
		src/cpu_dma_pkg.sv src/dma_wr_if.sv src/showahead_fifo.sv \
		src/bus_write_master.sv src/transfer_ctrl.sv src/fpga2cpu_dma.sv

clean:
	rm -rf $(OBJ) sim.log

/* verification/tb_fpga2cpu_dma.sv */
`timescale 1ns/100ps

module tb_fpga2cpu_dma;
    import cpu_dma_pkg::*;

    localparam int FIFO_DEPTH     = 16;
    localparam int MAX_BURST      = 8;
    localparam int PKT_RING       = 64;
    localparam int DSC_RING       = 16;
    localparam int RESET_CYCLES   = 8;
    localparam int TOTAL_FLITS    = 52;
    localparam int NUM_TESTS      = 6;
    // per flit and per test budget doubled for stalls and fetch delays
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + TOTAL_FLITS * 8 + NUM_TESTS * 120);

    logic        clk = 1'b0;
    logic        reset;
    flit_t       pkt_wr_data;
    logic        pkt_wr_en;
    rb_size_t    pkt_occup;
    pkt_desc_t   desc_wr_data;
    logic        desc_wr_en;
    rb_size_t    desc_occup;
    logic        queue_rd_en;
    qid_t        rd_pkt_queue;
    qid_t        rd_dsc_queue;
    logic        queue_ready = 1'b0;
    rb_ptr_t     in_dsc_head = '0;
    rb_ptr_t     in_dsc_tail = '0;
    logic [63:0] in_dsc_buf_addr = '0;
    rb_ptr_t     in_pkt_head = '0;
    rb_ptr_t     in_pkt_tail = '0;
    logic [63:0] in_pkt_buf_addr = '0;
    logic        in_pkt_q_needs_dsc = 1'b0;
    logic        tail_wr_en;
    qid_t        wr_pkt_queue;
    qid_t        wr_dsc_queue;
    rb_ptr_t     out_pkt_tail;
    rb_ptr_t     out_dsc_tail;
    rb_size_t    pkt_rb_size;
    rb_size_t    dsc_rb_size;
    logic [63:0] bus_address;
    logic [63:0] bus_byteenable;
    logic        bus_write;
    logic [511:0] bus_writedata;
    burst_t      bus_burstcount;
    logic        bus_waitrequest = 1'b0;

    // queue table indexed by the low queue id bits
    rb_ptr_t     tab_pkt_head [8];
    rb_ptr_t     tab_pkt_tail [8];
    logic [63:0] tab_pkt_addr [8];
    logic        tab_needs    [8];
    rb_ptr_t     tab_dsc_head [8];
    rb_ptr_t     tab_dsc_tail [8];
    logic [63:0] tab_dsc_addr [8];
    logic [31:0] q_rng = 32'h610c;
    logic [2:0]  q_delay = '0;
    qid_t        q_pkt_id;
    qid_t        q_dsc_id;
    int          fetch_count = 0;

    // bus beats as seen by host memory with one entry per flit
    logic [63:0]  beat_addr  [256];
    logic [511:0] beat_data  [256];
    burst_t       beat_burst [256];
    logic [63:0]  beat_be    [256];
    int           beat_cnt = 0;
    int           burst_left = 0;
    int           burst_idx = 0;
    logic [63:0]  burst_base;
    logic         prev_stall = 1'b0;
    logic [63:0]  prev_addr;
    logic [511:0] prev_data;
    burst_t       prev_burst;
    logic [31:0]  w_rng = 32'h610c;
    logic         wait_en = 1'b0;
    int           bus_errors = 0;

    logic [31:0]  data_rng = 32'h610c;
    logic [511:0] exp_data [64];
    int           checks = 0;
    int           errors = 0;
    int           cycle_cnt = 0;

    fpga2cpu_dma #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MAX_BURST  (MAX_BURST)
    ) i_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [511:0] random_flit();
        logic [511:0] d;
        for (int j = 0; j < 16; j++) begin
            data_rng = lcg(data_rng);
            d[j*32 +: 32] = data_rng;
        end
        return d;
    endfunction

    // queue table answers a fetch after 1 to 4 cycles
    always @(posedge clk) begin
        queue_ready <= 1'b0;
        if (reset) begin
            q_delay <= '0;
        end else if (queue_rd_en) begin
            q_rng       <= lcg(q_rng);
            q_delay     <= 3'd1 + 3'(q_rng[17:16]);
            q_pkt_id    <= rd_pkt_queue;
            q_dsc_id    <= rd_dsc_queue;
            fetch_count <= fetch_count + 1;
        end else if (q_delay != 0) begin
            q_delay <= q_delay - 1'b1;
            if (q_delay == 1) begin
                queue_ready        <= 1'b1;
                in_pkt_head        <= tab_pkt_head[q_pkt_id[2:0]];
                in_pkt_tail        <= tab_pkt_tail[q_pkt_id[2:0]];
                in_pkt_buf_addr    <= tab_pkt_addr[q_pkt_id[2:0]];
                in_pkt_q_needs_dsc <= tab_needs[q_pkt_id[2:0]];
                in_dsc_head        <= tab_dsc_head[q_dsc_id[2:0]];
                in_dsc_tail        <= tab_dsc_tail[q_dsc_id[2:0]];
                in_dsc_buf_addr    <= tab_dsc_addr[q_dsc_id[2:0]];
            end
        end
    end

    // host memory side records beats and drives waitrequest
    always @(posedge clk) begin
        w_rng           <= lcg(w_rng);
        bus_waitrequest <= wait_en && w_rng[16];
        if (!reset && prev_stall) begin
            assert (bus_write && bus_address == prev_addr && bus_writedata == prev_data
                    && bus_burstcount == prev_burst) else begin
                bus_errors <= bus_errors + 1;
                $display("bus outputs changed while a write was held by waitrequest");
            end
        end
        prev_stall <= !reset && bus_write && bus_waitrequest;
        prev_addr  <= bus_address;
        prev_data  <= bus_writedata;
        prev_burst <= bus_burstcount;
        if (!reset && bus_write && !bus_waitrequest) begin
            if (burst_left == 0) begin
                beat_addr[beat_cnt]  <= bus_address;
                beat_burst[beat_cnt] <= bus_burstcount;
                burst_base           <= bus_address;
                burst_idx            <= 1;
                burst_left           <= int'(bus_burstcount) - 1;
            end else begin
                beat_addr[beat_cnt]  <= burst_base + 64'(burst_idx) * 64'(FLIT_BYTES);
                beat_burst[beat_cnt] <= '0;
                burst_idx            <= burst_idx + 1;
                burst_left           <= burst_left - 1;
            end
            beat_data[beat_cnt] <= bus_writedata;
            beat_be[beat_cnt]   <= bus_byteenable;
            beat_cnt            <= beat_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input string what,
                             input logic [511:0] expected, input logic [511:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("MISMATCH %s %s: expected %0h, actual %0h", name, what, expected, actual);
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s: %s", name, what);
        end
    endtask

    task automatic send_packet(input string name, input int q, input int n);
        pkt_desc_t desc;
        flit_t     flit;
        int        i;
        int        cyc;
        desc.pkt_queue_id = qid_t'(q);
        desc.dsc_queue_id = qid_t'(q + 16);
        desc.size         = PKT_SIZE_WIDTH'(n);
        @(posedge clk);
        desc_wr_data <= desc;
        desc_wr_en   <= 1'b1;
        i   = 0;
        cyc = 0;
        while (i < n) begin
            @(posedge clk);
            desc_wr_en <= 1'b0;
            cyc++;
            // the descriptor shows in the buffer level two edges after its write
            if (cyc == 2) begin
                check_val(name, "descriptor level", 0, desc_occup);
            end else if (cyc == 3) begin
                check_val(name, "descriptor level", 1, desc_occup);
            end
            // occupancy trails the writes by two cycles
            if (pkt_occup < rb_size_t'(FIFO_DEPTH - 4)) begin
                flit.sop    = (i == 0);
                flit.eop    = (i == n - 1);
                flit.data   = random_flit();
                exp_data[i] = flit.data;
                pkt_wr_data <= flit;
                pkt_wr_en   <= 1'b1;
                i++;
            end else begin
                pkt_wr_en <= 1'b0;
            end
        end
        @(posedge clk);
        pkt_wr_en <= 1'b0;
    endtask

    task automatic run_packet(input string name, input int q, input int n, input int tail0,
                              input int head0, input logic needs, input logic full_ring,
                              input logic stall);
        int          start;
        int          fetch0;
        int          errs0;
        int          checks0;
        int          pos;
        int          slot;
        int          blen;
        int          exp_beats;
        logic [63:0] pkt_base;
        logic [63:0] dsc_base;
        rb_ptr_t     wb_pkt_tail;
        rb_ptr_t     wb_dsc_tail;
        qid_t        wb_pkt_q;
        qid_t        wb_dsc_q;
        cpl_desc_t   exp_cpl;
        pkt_base  = 64'h1_0000_0000 + 64'(q) * 64'h10_0000;
        dsc_base  = 64'h2_0000_0000 + 64'(q) * 64'h1000;
        exp_beats = n + (needs ? 1 : 0);
        @(posedge clk);
        tab_pkt_head[q] <= rb_ptr_t'(head0);
        tab_pkt_tail[q] <= rb_ptr_t'(tail0);
        tab_pkt_addr[q] <= pkt_base;
        tab_needs[q]    <= needs;
        tab_dsc_head[q] <= '0;
        tab_dsc_tail[q] <= rb_ptr_t'(q);
        tab_dsc_addr[q] <= dsc_base;
        wait_en         <= stall;
        start   = beat_cnt;
        fetch0  = fetch_count;
        errs0   = errors + bus_errors;
        checks0 = checks;
        send_packet(name, q, n);
        if (full_ring) begin
            repeat (40) @(posedge clk);
            check_val(name, "beats while full", 0, beat_cnt - start);
            check_val(name, "packet level while full", n, pkt_occup);
            check_true(name, fetch_count - fetch0 >= 2,
                       "queue state was not fetched again while the ring was full");
            // CPU consumes twenty slots
            tab_pkt_head[q] <= rb_ptr_t'((head0 + 20) % PKT_RING);
        end
        @(posedge clk);
        while (tail_wr_en !== 1'b1) @(posedge clk);
        wb_pkt_tail = out_pkt_tail;
        wb_dsc_tail = out_dsc_tail;
        wb_pkt_q    = wr_pkt_queue;
        wb_dsc_q    = wr_dsc_queue;
        tab_pkt_tail[wb_pkt_q[2:0]] <= wb_pkt_tail;
        tab_dsc_tail[wb_dsc_q[2:0]] <= wb_dsc_tail;
        while (beat_cnt - start < exp_beats) @(posedge clk);
        repeat (4) @(posedge clk);
        wait_en <= 1'b0;
        check_val(name, "beat count", exp_beats, beat_cnt - start);
        check_val(name, "packet level", 0, pkt_occup);
        check_val(name, "descriptor level", 0, desc_occup);

        // bursts end at the packet end, at MAX_BURST and at the ring end
        pos  = 0;
        slot = tail0;
        while (pos < n) begin
            blen = n - pos;
            if (blen > MAX_BURST) blen = MAX_BURST;
            if (blen > PKT_RING - slot) blen = PKT_RING - slot;
            for (int k = 0; k < blen; k++) begin
                check_val(name, "burstcount", (k == 0) ? blen : 0, beat_burst[start + pos]);
                check_val(name, "address", pkt_base + 64'(slot) * 64,
                          beat_addr[start + pos]);
                check_val(name, "flit data", exp_data[pos], beat_data[start + pos]);
                check_val(name, "byteenable", 64'hFFFF_FFFF_FFFF_FFFF, beat_be[start + pos]);
                pos++;
                slot = (slot + 1) % PKT_RING;
            end
        end
        if (needs) begin
            exp_cpl          = '0;
            exp_cpl.signal   = 1'b1;
            exp_cpl.tail     = 32'(slot);
            exp_cpl.queue_id = qid_t'(q);
            check_val(name, "descriptor address", dsc_base + 64'(q) * 64, beat_addr[start + n]);
            check_val(name, "descriptor burstcount", 1, beat_burst[start + n]);
            check_val(name, "descriptor data", exp_cpl, beat_data[start + n]);
            check_val(name, "descriptor byteenable", 64'hFFFF_FFFF_FFFF_FFFF,
                      beat_be[start + n]);
        end
        check_val(name, "fetched packet queue", q, q_pkt_id);
        check_val(name, "fetched descriptor queue", q + 16, q_dsc_id);
        check_val(name, "packet tail", slot, wb_pkt_tail);
        check_val(name, "descriptor tail", needs ? (q + 1) % DSC_RING : q, wb_dsc_tail);
        check_val(name, "packet queue", q, wb_pkt_q);
        check_val(name, "descriptor queue", q + 16, wb_dsc_q);
        $display("%s: %0d checks, %0d errors", name, checks - checks0,
                 errors + bus_errors - errs0);
    endtask

    initial begin
        int total_errors;
        reset        = 1'b1;
        pkt_wr_data  = '0;
        pkt_wr_en    = 1'b0;
        desc_wr_data = '0;
        desc_wr_en   = 1'b0;
        pkt_rb_size  = rb_size_t'(PKT_RING);
        dsc_rb_size  = rb_size_t'(DSC_RING);
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        run_packet("short_packet", 1, 3, 5, 0, 1'b1, 1'b0, 1'b0);
        run_packet("burst_split", 2, 20, 8, 0, 1'b1, 1'b0, 1'b0);
        run_packet("ring_wrap", 3, 6, 61, 10, 1'b1, 1'b0, 1'b0);
        run_packet("full_ring", 4, 6, 10, 14, 1'b1, 1'b1, 1'b0);
        run_packet("back_pressure", 5, 12, 20, 0, 1'b1, 1'b0, 1'b1);
        run_packet("no_descriptor", 6, 5, 30, 0, 1'b0, 1'b0, 1'b0);

        total_errors = errors + bus_errors;
        $display("summary: %0d checks, %0d errors", checks, total_errors);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src/fpga2cpu_dma.sv */
`timescale 1ns/100ps

module fpga2cpu_dma #(
    parameter int FIFO_DEPTH = 16,
    parameter int MAX_BURST  = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,

    // packet and descriptor buffers
    input  cpu_dma_pkg::flit_t                    pkt_wr_data,
    input  logic                                  pkt_wr_en,
    output cpu_dma_pkg::rb_size_t                 pkt_occup,
    input  cpu_dma_pkg::pkt_desc_t                desc_wr_data,
    input  logic                                  desc_wr_en,
    output cpu_dma_pkg::rb_size_t                 desc_occup,

    // queue table
    output logic                                  queue_rd_en,
    output cpu_dma_pkg::qid_t                     rd_pkt_queue,
    output cpu_dma_pkg::qid_t                     rd_dsc_queue,
    input  logic                                  queue_ready,
    input  cpu_dma_pkg::rb_ptr_t                  in_dsc_head,
    input  cpu_dma_pkg::rb_ptr_t                  in_dsc_tail,
    input  logic [63:0]                           in_dsc_buf_addr,
    input  cpu_dma_pkg::rb_ptr_t                  in_pkt_head,
    input  cpu_dma_pkg::rb_ptr_t                  in_pkt_tail,
    input  logic [63:0]                           in_pkt_buf_addr,
    input  logic                                  in_pkt_q_needs_dsc,
    output logic                                  tail_wr_en,
    output cpu_dma_pkg::qid_t                     wr_pkt_queue,
    output cpu_dma_pkg::qid_t                     wr_dsc_queue,
    output cpu_dma_pkg::rb_ptr_t                  out_pkt_tail,
    output cpu_dma_pkg::rb_ptr_t                  out_dsc_tail,
    input  cpu_dma_pkg::rb_size_t                 pkt_rb_size,
    input  cpu_dma_pkg::rb_size_t                 dsc_rb_size,

    // host memory bus
    output logic [63:0]                           bus_address,
    output logic [cpu_dma_pkg::FLIT_BYTES-1:0]    bus_byteenable,
    output logic                                  bus_write,
    output logic [cpu_dma_pkg::FLIT_BITS-1:0]     bus_writedata,
    output cpu_dma_pkg::burst_t                   bus_burstcount,
    input  logic                                  bus_waitrequest
);
    import cpu_dma_pkg::*;

    flit_t     pkt_wr_data_r;
    logic      pkt_wr_en_r;
    pkt_desc_t desc_wr_data_r;
    logic      desc_wr_en_r;
    flit_t     pkt_head_flit;
    pkt_desc_t desc_head;
    logic      pkt_rd_en;
    logic      desc_rd_en;

    dma_wr_if wr_if ();

    // one register stage in front of the buffers eases input timing
    always_ff @(posedge clk) begin
        pkt_wr_data_r  <= pkt_wr_data;
        desc_wr_data_r <= desc_wr_data;
        if (reset) begin
            pkt_wr_en_r  <= 1'b0;
            desc_wr_en_r <= 1'b0;
        end else begin
            pkt_wr_en_r  <= pkt_wr_en;
            desc_wr_en_r <= desc_wr_en;
        end
    end

    showahead_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (flit_t)
    ) i_pkt_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_data (pkt_wr_data_r),
        .wr_en   (pkt_wr_en_r),
        .rd_en   (pkt_rd_en),
        .rd_data (pkt_head_flit),
        .occup   (pkt_occup)
    );

    showahead_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (pkt_desc_t)
    ) i_desc_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_data (desc_wr_data_r),
        .wr_en   (desc_wr_en_r),
        .rd_en   (desc_rd_en),
        .rd_data (desc_head),
        .occup   (desc_occup)
    );

    transfer_ctrl #(
        .MAX_BURST (MAX_BURST)
    ) i_ctrl (
        .clk                (clk),
        .reset              (reset),
        .pkt_head_flit      (pkt_head_flit),
        .pkt_occup          (pkt_occup),
        .desc_head          (desc_head),
        .desc_occup         (desc_occup),
        .pkt_rd_en          (pkt_rd_en),
        .desc_rd_en         (desc_rd_en),
        .queue_ready        (queue_ready),
        .in_dsc_head        (in_dsc_head),
        .in_dsc_tail        (in_dsc_tail),
        .in_dsc_buf_addr    (in_dsc_buf_addr),
        .in_pkt_head        (in_pkt_head),
        .in_pkt_tail        (in_pkt_tail),
        .in_pkt_buf_addr    (in_pkt_buf_addr),
        .in_pkt_q_needs_dsc (in_pkt_q_needs_dsc),
        .pkt_rb_size        (pkt_rb_size),
        .dsc_rb_size        (dsc_rb_size),
        .queue_rd_en        (queue_rd_en),
        .rd_pkt_queue       (rd_pkt_queue),
        .rd_dsc_queue       (rd_dsc_queue),
        .tail_wr_en         (tail_wr_en),
        .wr_pkt_queue       (wr_pkt_queue),
        .wr_dsc_queue       (wr_dsc_queue),
        .out_pkt_tail       (out_pkt_tail),
        .out_dsc_tail       (out_dsc_tail),
        .req                (wr_if.source)
    );

    bus_write_master i_master (
        .clk             (clk),
        .reset           (reset),
        .req             (wr_if.sink),
        .bus_waitrequest (bus_waitrequest),
        .bus_address     (bus_address),
        .bus_byteenable  (bus_byteenable),
        .bus_write       (bus_write),
        .bus_writedata   (bus_writedata),
        .bus_burstcount  (bus_burstcount)
    );

endmodule

/* src/transfer_ctrl.sv */
`timescale 1ns/100ps

module transfer_ctrl #(
    parameter int MAX_BURST = 8
) (
    input  logic                    clk,
    input  logic                    reset,

    // input buffers
    input  cpu_dma_pkg::flit_t      pkt_head_flit,
    input  cpu_dma_pkg::rb_size_t   pkt_occup,
    input  cpu_dma_pkg::pkt_desc_t  desc_head,
    input  cpu_dma_pkg::rb_size_t   desc_occup,
    output logic                    pkt_rd_en,
    output logic                    desc_rd_en,

    // queue table
    input  logic                    queue_ready,
    input  cpu_dma_pkg::rb_ptr_t    in_dsc_head,
    input  cpu_dma_pkg::rb_ptr_t    in_dsc_tail,
    input  logic [63:0]             in_dsc_buf_addr,
    input  cpu_dma_pkg::rb_ptr_t    in_pkt_head,
    input  cpu_dma_pkg::rb_ptr_t    in_pkt_tail,
    input  logic [63:0]             in_pkt_buf_addr,
    input  logic                    in_pkt_q_needs_dsc,
    input  cpu_dma_pkg::rb_size_t   pkt_rb_size,
    input  cpu_dma_pkg::rb_size_t   dsc_rb_size,
    output logic                    queue_rd_en,
    output cpu_dma_pkg::qid_t       rd_pkt_queue,
    output cpu_dma_pkg::qid_t       rd_dsc_queue,
    output logic                    tail_wr_en,
    output cpu_dma_pkg::qid_t       wr_pkt_queue,
    output cpu_dma_pkg::qid_t       wr_dsc_queue,
    output cpu_dma_pkg::rb_ptr_t    out_pkt_tail,
    output cpu_dma_pkg::rb_ptr_t    out_dsc_tail,

    // write beats towards the bus master
    dma_wr_if.source                req
);
    import cpu_dma_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_wait,
        st_burst_start,
        st_burst_cont,
        st_desc
    } state_t;

    state_t                    state;
    pkt_desc_t                 cur_desc;
    rb_ptr_t                   pkt_head;
    rb_ptr_t                   pkt_tail;
    rb_ptr_t                   dsc_head;
    rb_ptr_t                   dsc_tail;
    logic [63:0]               pkt_buf_addr;
    logic [63:0]               dsc_buf_addr;
    logic                      needs_dsc;
    logic [PKT_SIZE_WIDTH-1:0] missing;
    burst_t                    burst_left;

    rb_ptr_t                   pkt_free;
    rb_ptr_t                   dsc_free;
    logic                      space_ok;
    rb_size_t                  slots_to_end;
    logic [PKT_SIZE_WIDTH-1:0] len_w;
    burst_t                    burst_len;
    cpl_desc_t                 cpl;
    logic                      pkt_beat;
    logic                      beat_acc;

    // free slots with wraparound, one slot always stays empty
    function automatic rb_ptr_t free_slots(rb_ptr_t head, rb_ptr_t tail, rb_size_t size);
        if (tail >= head) begin
            return rb_ptr_t'(size - rb_size_t'(tail) + rb_size_t'(head) - 1'b1);
        end
        return head - tail - 1'b1;
    endfunction

    function automatic rb_ptr_t ptr_inc(rb_ptr_t ptr, rb_size_t size);
        if (rb_size_t'(ptr) + 1'b1 >= size) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pkt_free = free_slots(pkt_head, pkt_tail, pkt_rb_size);
    assign dsc_free = free_slots(dsc_head, dsc_tail, dsc_rb_size);
    assign space_ok = (pkt_free >= missing) && (dsc_free != 0);

    // burst length is bounded by the packet, MAX_BURST and the ring end
    always_comb begin
        slots_to_end = pkt_rb_size - rb_size_t'(pkt_tail);
        len_w = missing;
        if (len_w > MAX_BURST) begin
            len_w = PKT_SIZE_WIDTH'(MAX_BURST);
        end
        if (rb_size_t'(len_w) > slots_to_end) begin
            len_w = slots_to_end[PKT_SIZE_WIDTH-1:0];
        end
        burst_len = burst_t'(len_w);
    end

    always_comb begin
        cpl          = '0;
        cpl.signal   = 1'b1;
        cpl.tail     = 32'(pkt_tail);
        cpl.queue_id = cur_desc.pkt_queue_id;

        req.valid      = 1'b0;
        req.first      = 1'b0;
        req.address    = pkt_buf_addr + 64'(pkt_tail) * 64'(FLIT_BYTES);
        req.burstcount = burst_len;
        req.writedata  = pkt_head_flit.data;
        case (state)
            st_burst_start: begin
                req.valid = space_ok && (pkt_occup != 0);
                req.first = 1'b1;
            end
            st_burst_cont: begin
                req.valid = (pkt_occup != 0);
            end
            st_desc: begin
                req.valid      = needs_dsc;
                req.first      = 1'b1;
                req.address    = dsc_buf_addr + 64'(dsc_tail) * 64'(FLIT_BYTES);
                req.burstcount = burst_t'(1);
                req.writedata  = cpl;
            end
            default: begin
            end
        endcase
    end

    assign beat_acc   = req.valid && req.ready;
    assign pkt_beat   = (state == st_burst_start) || (state == st_burst_cont);
    // one flit leaves the buffer per accepted packet beat
    assign pkt_rd_en  = beat_acc && pkt_beat;
    assign desc_rd_en = (state == st_idle) && (desc_occup != 0) && (pkt_occup != 0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            queue_rd_en <= 1'b0;
            tail_wr_en  <= 1'b0;
        end else begin
            queue_rd_en <= 1'b0;
            tail_wr_en  <= 1'b0;
            case (state)
                st_idle: begin
                    if (desc_rd_en) begin
                        cur_desc     <= desc_head;
                        missing      <= desc_head.size;
                        rd_pkt_queue <= desc_head.pkt_queue_id;
                        rd_dsc_queue <= desc_head.dsc_queue_id;
                        queue_rd_en  <= 1'b1;
                        state        <= st_fetch_wait;
                    end
                end
                st_fetch_wait: begin
                    if (queue_ready) begin
                        pkt_head     <= in_pkt_head;
                        pkt_tail     <= in_pkt_tail;
                        pkt_buf_addr <= in_pkt_buf_addr;
                        dsc_head     <= in_dsc_head;
                        dsc_tail     <= in_dsc_tail;
                        dsc_buf_addr <= in_dsc_buf_addr;
                        needs_dsc    <= in_pkt_q_needs_dsc;
                        state        <= st_burst_start;
                    end
                end
                st_burst_start: begin
                    if (!space_ok) begin
                        // ring full, ask again for fresh heads
                        rd_pkt_queue <= cur_desc.pkt_queue_id;
                        rd_dsc_queue <= cur_desc.dsc_queue_id;
                        queue_rd_en  <= 1'b1;
                        state        <= st_fetch_wait;
                    end else if (beat_acc) begin
                        pkt_tail   <= ptr_inc(pkt_tail, pkt_rb_size);
                        missing    <= missing - 1'b1;
                        burst_left <= burst_len - 1'b1;
                        if (missing == 1) begin
                            state <= st_desc;
                        end else if (burst_len != 1) begin
                            state <= st_burst_cont;
                        end
                    end
                end
                st_burst_cont: begin
                    if (beat_acc) begin
                        pkt_tail   <= ptr_inc(pkt_tail, pkt_rb_size);
                        missing    <= missing - 1'b1;
                        burst_left <= burst_left - 1'b1;
                        if (missing == 1) begin
                            state <= st_desc;
                        end else if (burst_left == 1) begin
                            state <= st_burst_start;
                        end
                    end
                end
                st_desc: begin
                    if (beat_acc || !needs_dsc) begin
                        out_pkt_tail <= pkt_tail;
                        out_dsc_tail <= needs_dsc ? ptr_inc(dsc_tail, dsc_rb_size) : dsc_tail;
                        wr_pkt_queue <= cur_desc.pkt_queue_id;
                        wr_dsc_queue <= cur_desc.dsc_queue_id;
                        tail_wr_en   <= 1'b1;
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // flit framing in the packet buffer must agree with the descriptor size
    a_first_sop: assert property (@(posedge clk) disable iff (reset)
        pkt_rd_en && (missing == cur_desc.size) |-> pkt_head_flit.sop);
    a_last_eop: assert property (@(posedge clk) disable iff (reset)
        pkt_rd_en && (missing == 1) |-> pkt_head_flit.eop);

endmodule

/* src/bus_write_master.sv */
`timescale 1ns/100ps

module bus_write_master (
    input  logic                                  clk,
    input  logic                                  reset,
    dma_wr_if.sink                                req,
    input  logic                                  bus_waitrequest,
    output logic [63:0]                           bus_address,
    output logic [cpu_dma_pkg::FLIT_BYTES-1:0]    bus_byteenable,
    output logic                                  bus_write,
    output logic [cpu_dma_pkg::FLIT_BITS-1:0]     bus_writedata,
    output cpu_dma_pkg::burst_t                   bus_burstcount
);
    logic accept;

    // the output register frees up when idle or when the bus takes the beat
    assign req.ready = !bus_write || !bus_waitrequest;
    assign accept    = req.valid && req.ready;

    // full flit writes only
    assign bus_byteenable = '1;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_write <= 1'b0;
        end else if (req.ready) begin
            bus_write <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_writedata <= req.writedata;
            // address and count only mean something on a burst's first beat
            if (req.first) begin
                bus_address    <= req.address;
                bus_burstcount <= req.burstcount;
            end
        end
    end

    // a burst that opens with count zero is illegal on the bus
    a_burst_nonzero: assert property (@(posedge clk) disable iff (reset)
        accept && req.first |-> req.burstcount != 0);

endmodule

/* src/showahead_fifo.sv */
`timescale 1ns/100ps

module showahead_fifo #(
    parameter int  FIFO_DEPTH = 16,
    parameter type payload_t  = logic
) (
    input  logic                  clk,
    input  logic                  reset,
    input  payload_t              wr_data,
    input  logic                  wr_en,
    input  logic                  rd_en,
    output payload_t              rd_data,
    output cpu_dma_pkg::rb_size_t occup
);
    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    payload_t      mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          push;
    logic          pop;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        if (ptr == AW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (occup == FIFO_DEPTH);
    // a write into a full buffer is dropped
    assign push = wr_en && !full;
    assign pop  = rd_en && (occup != 0);

    // head entry is always on the output
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occup  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            occup <= occup + push - pop;
        end
    end

    // the source must watch occupancy, the reader must watch it too
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(wr_en && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(rd_en && occup == 0));

endmodule

/* src/dma_wr_if.sv */
`timescale 1ns/100ps

interface dma_wr_if;
    import cpu_dma_pkg::*;

    logic                 valid;
    logic                 ready;
    logic [63:0]          address;
    burst_t               burstcount;
    logic [FLIT_BITS-1:0] writedata;
    // marks the beat that opens a burst
    logic                 first;

    modport source (
        output valid,
        output address,
        output burstcount,
        output writedata,
        output first,
        input  ready
    );

    modport sink (
        input  valid,
        input  address,
        input  burstcount,
        input  writedata,
        input  first,
        output ready
    );

endinterface

/* src/cpu_dma_pkg.sv */
package cpu_dma_pkg;

    // flit and ring geometry
    localparam int FLIT_BITS      = 512;
    localparam int FLIT_BYTES     = 64;
    localparam int RB_AWIDTH      = 16;
    localparam int QID_WIDTH      = 9;
    localparam int PKT_SIZE_WIDTH = 16;

    typedef logic [RB_AWIDTH-1:0] rb_ptr_t;
    typedef logic [RB_AWIDTH:0]   rb_size_t;
    typedef logic [QID_WIDTH-1:0] qid_t;

    // bus burst count of at most 15 flits
    typedef logic [3:0] burst_t;

    typedef struct packed {
        logic                 sop;
        logic                 eop;
        logic [FLIT_BITS-1:0] data;
    } flit_t;

    // one descriptor per packet, size counted in flits
    typedef struct packed {
        qid_t                      pkt_queue_id;
        qid_t                      dsc_queue_id;
        logic [PKT_SIZE_WIDTH-1:0] size;
    } pkt_desc_t;

    // completion descriptor written to the CPU descriptor ring
    // tail is the packet ring tail after the packet, zero extended
    typedef struct packed {
        logic                                signal;
        logic [31:0]                         tail;
        qid_t                                queue_id;
        logic [FLIT_BITS-33-QID_WIDTH-1:0]   pad;
    } cpl_desc_t;

endpackage
